// ==== source/noc_pkg.sv ====
/* noc package
   mesh geometry, flit layout and router port numbering */
package noc_pkg;

        // default mesh size, overridden from the top level
        localparam int mesh_x = 3;
        localparam int mesh_y = 3;

        // field widths
        localparam int coord_w = 2;
        localparam int data_w = 32;

        // four neighbours plus the local port
        localparam int num_ports = 5;

        typedef logic [coord_w-1:0] coord_t;

        // one flit is one whole packet, 40 bits
        typedef struct packed {
                coord_t            dst_x;
                coord_t            dst_y;
                coord_t            src_x;
                coord_t            src_y;
                logic [data_w-1:0] data;
        } flit_t;

        // router port numbering
        typedef enum logic [2:0] {
                port_north = 3'd0,      // toward smaller y
                port_east  = 3'd1,      // toward larger x
                port_south = 3'd2,      // toward larger y
                port_west  = 3'd3,      // toward smaller x
                port_local = 3'd4
        } port_e;

endpackage

// ==== source/noc_link_if.sv ====
/* noc link
   one directed valid/ready flit link, router to router or local */
interface noc_link_if;
        import noc_pkg::*;

        // sender side
        logic  valid;
        flit_t flit;
        // receiver side
        logic  rdy;
        // link direction, for messages only
        port_e dir;

        modport tx (output valid, output flit, input rdy, input dir);
        modport rx (input valid, input flit, output rdy, input dir);

endinterface

// ==== source/noc_input_fifo.sv ====
/* noc input fifo
   per-port circular flit buffer, rdy high while not full */
module noc_input_fifo #(
        parameter int fifo_depth = 2
) (
        input  logic           clk,
        input  logic           rst_n,
        noc_link_if.rx         in_link,
        output noc_pkg::flit_t head,
        output logic           head_valid,
        input  logic           pop
);
        import noc_pkg::*;

        localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
        localparam int cnt_w = $clog2(fifo_depth + 1);

        flit_t            mem [fifo_depth];
        logic [ptr_w-1:0] wr_ptr;
        logic [ptr_w-1:0] rd_ptr;
        logic [cnt_w-1:0] count;
        logic             push;

        // write on every link transfer
        assign push = in_link.valid && in_link.rdy;
        assign in_link.rdy = (count != cnt_w'(fifo_depth));

        // head shows up the cycle after its write
        assign head = mem[rd_ptr];
        assign head_valid = (count != '0);

        always_ff @(posedge clk) begin
                if (push)
                        mem[wr_ptr] <= in_link.flit;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count <= '0;
                end else begin
                        // pointers wrap at depth, which need not be a power of two
                        if (push)
                                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
                        if (pop)
                                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
                        unique case ({push, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // the arbiter only grants a valid head
        a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
                pop |-> head_valid)
                else $error("%s input fifo popped while empty", in_link.dir.name());

endmodule

// ==== source/noc_output_arbiter.sv ====
/* noc output arbiter
   round-robin pick among inputs requesting this output, registered link stage */
module noc_output_arbiter (
        input  logic                          clk,
        input  logic                          rst_n,
        input  logic [noc_pkg::num_ports-1:0] req,
        input  noc_pkg::flit_t                cand [noc_pkg::num_ports],
        output logic [noc_pkg::num_ports-1:0] grant,
        noc_link_if.tx                        out_link
);
        import noc_pkg::*;

        localparam int idx_w = $clog2(num_ports);

        logic [idx_w-1:0] rr_ptr;
        logic [idx_w-1:0] win;
        logic             any_req;
        logic             can_load;

        // output register empty or draining this cycle
        assign can_load = !out_link.valid || out_link.rdy;

        // scan from rr_ptr, nearest requester wins
        always_comb begin
                int idx;
                win = '0;
                any_req = 1'b0;
                for (int i = num_ports - 1; i >= 0; i--) begin
                        idx = (int'(rr_ptr) + i) % num_ports;
                        if (req[idx]) begin
                                win = idx_w'(idx);
                                any_req = 1'b1;
                        end
                end
        end

        // no grant while the register is held by back-pressure
        assign grant = (any_req && can_load) ? (num_ports'(1) << win) : '0;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_link.valid <= 1'b0;
                        rr_ptr <= '0;
                end else if (|grant) begin
                        out_link.valid <= 1'b1;
                        // move past the winner
                        rr_ptr <= (win == idx_w'(num_ports - 1)) ? '0 : win + 1'b1;
                end else if (out_link.rdy) begin
                        out_link.valid <= 1'b0;
                end
        end

        // winning flit, held until the link transfer
        always_ff @(posedge clk) begin
                if (|grant)
                        out_link.flit <= cand[win];
        end

        a_grant_ok: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(grant) && ((grant & ~req) == '0))
                else $error("%s arbiter bad grant %b for req %b",
                        out_link.dir.name(), grant, req);

endmodule

// ==== source/noc_router.sv ====
/* noc router
   five-port router, input fifos, xy route compute, per-output arbiters */
module noc_router #(
        parameter int my_x = 0,
        parameter int my_y = 0,
        parameter int mesh_x = noc_pkg::mesh_x,
        parameter int mesh_y = noc_pkg::mesh_y,
        parameter int fifo_depth = 2
) (
        input  logic   clk,
        input  logic   rst_n,
        noc_link_if.rx in_link [noc_pkg::num_ports],
        noc_link_if.tx out_link [noc_pkg::num_ports]
);
        import noc_pkg::*;

        flit_t                head [num_ports];
        logic [num_ports-1:0] head_valid;
        logic [num_ports-1:0] pop;
        port_e                route [num_ports];
        // indexed [output][input]
        logic [num_ports-1:0] req [num_ports];
        logic [num_ports-1:0] grant [num_ports];
        logic                 off_mesh;

        for (genvar i = 0; i < num_ports; i++) begin : g_in
                noc_input_fifo #(
                        .fifo_depth (fifo_depth)
                ) u_fifo (
                        .clk        (clk),
                        .rst_n      (rst_n),
                        .in_link    (in_link[i]),
                        .head       (head[i]),
                        .head_valid (head_valid[i]),
                        .pop        (pop[i])
                );
        end

        // x first, then y, then local
        always_comb begin
                for (int i = 0; i < num_ports; i++) begin
                        if (head[i].dst_x > coord_t'(my_x))
                                route[i] = port_east;
                        else if (head[i].dst_x < coord_t'(my_x))
                                route[i] = port_west;
                        else if (head[i].dst_y > coord_t'(my_y))
                                route[i] = port_south;
                        else if (head[i].dst_y < coord_t'(my_y))
                                route[i] = port_north;
                        else
                                route[i] = port_local;
                end
        end

        // each valid head requests its one output
        always_comb begin
                for (int o = 0; o < num_ports; o++)
                        for (int i = 0; i < num_ports; i++)
                                req[o][i] = head_valid[i] && (route[i] == port_e'(o));
        end

        // a grant on any output pops that input
        always_comb begin
                pop = '0;
                for (int o = 0; o < num_ports; o++)
                        pop = pop | grant[o];
        end

        for (genvar o = 0; o < num_ports; o++) begin : g_out
                noc_output_arbiter u_arb (
                        .clk      (clk),
                        .rst_n    (rst_n),
                        .req      (req[o]),
                        .cand     (head),
                        .grant    (grant[o]),
                        .out_link (out_link[o])
                );
        end

        // edge routers must never aim past the border
        assign off_mesh = (|req[port_east] && my_x == mesh_x - 1) ||
                          (|req[port_west] && my_x == 0) ||
                          (|req[port_south] && my_y == mesh_y - 1) ||
                          (|req[port_north] && my_y == 0);

        a_on_mesh: assert property (@(posedge clk) disable iff (!rst_n) !off_mesh)
                else $error("router (%0d,%0d) routes a flit off the mesh", my_x, my_y);

endmodule

// ==== source/noc_inject.sv ====
/* noc inject
   per-node one-entry register, builds flits from the local client ports */
module noc_inject #(
        parameter int mesh_x = noc_pkg::mesh_x,
        parameter int mesh_y = noc_pkg::mesh_y
) (
        input  logic                         clk,
        input  logic                         rst_n,
        input  logic [mesh_x*mesh_y-1:0]     ivalid,
        input  noc_pkg::coord_t              idst_x [mesh_x*mesh_y],
        input  noc_pkg::coord_t              idst_y [mesh_x*mesh_y],
        input  logic [noc_pkg::data_w-1:0]   idata [mesh_x*mesh_y],
        output logic [mesh_x*mesh_y-1:0]     ordy,
        noc_link_if.tx                       inj [mesh_x*mesh_y]
);
        import noc_pkg::*;

        for (genvar n = 0; n < mesh_x * mesh_y; n++) begin : g_node
                // empty or draining
                assign ordy[n] = !inj[n].valid || inj[n].rdy;

                always_ff @(posedge clk or negedge rst_n) begin
                        if (!rst_n)
                                inj[n].valid <= 1'b0;
                        else if (ordy[n])
                                inj[n].valid <= ivalid[n];
                end

                // source stamped from the node index
                always_ff @(posedge clk) begin
                        if (ivalid[n] && ordy[n]) begin
                                inj[n].flit <= '{dst_x: idst_x[n],
                                                 dst_y: idst_y[n],
                                                 src_x: coord_t'(n % mesh_x),
                                                 src_y: coord_t'(n / mesh_x),
                                                 data:  idata[n]};
                        end
                end
        end

endmodule

// ==== source/noc_eject.sv ====
/* noc eject
   per-node output registers, one-cycle ovalid strobe, no back-pressure */
module noc_eject #(
        parameter int mesh_x = noc_pkg::mesh_x,
        parameter int mesh_y = noc_pkg::mesh_y
) (
        input  logic                       clk,
        input  logic                       rst_n,
        noc_link_if.rx                     ej [mesh_x*mesh_y],
        output logic [mesh_x*mesh_y-1:0]   ovalid,
        output logic [noc_pkg::data_w-1:0] odata [mesh_x*mesh_y],
        output noc_pkg::coord_t            osrc_x [mesh_x*mesh_y],
        output noc_pkg::coord_t            osrc_y [mesh_x*mesh_y]
);
        import noc_pkg::*;

        for (genvar n = 0; n < mesh_x * mesh_y; n++) begin : g_node
                // local client always accepts
                assign ej[n].rdy = 1'b1;

                always_ff @(posedge clk or negedge rst_n) begin
                        if (!rst_n)
                                ovalid[n] <= 1'b0;
                        else
                                ovalid[n] <= ej[n].valid && ej[n].rdy;
                end

                always_ff @(posedge clk) begin
                        if (ej[n].valid) begin
                                odata[n] <= ej[n].flit.data;
                                osrc_x[n] <= ej[n].flit.src_x;
                                osrc_y[n] <= ej[n].flit.src_y;
                        end
                end

                // xy routing must land the flit on its own node
                a_dest: assert property (@(posedge clk) disable iff (!rst_n)
                        ej[n].valid |-> (ej[n].flit.dst_x == coord_t'(n % mesh_x) &&
                                         ej[n].flit.dst_y == coord_t'(n / mesh_x)))
                        else $error("node %0d got flit for (%0d,%0d)",
                                n, ej[n].flit.dst_x, ej[n].flit.dst_y);
        end

endmodule

// ==== source/noc_mesh.sv ====
/* noc mesh
   top level, router grid with neighbour links, edge tie-offs and local ports */
module noc_mesh #(
        parameter int mesh_x = noc_pkg::mesh_x,
        parameter int mesh_y = noc_pkg::mesh_y,
        parameter int fifo_depth = 2
) (
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic [mesh_x*mesh_y-1:0]   ivalid,
        input  noc_pkg::coord_t            idst_x [mesh_x*mesh_y],
        input  noc_pkg::coord_t            idst_y [mesh_x*mesh_y],
        input  logic [noc_pkg::data_w-1:0] idata [mesh_x*mesh_y],
        output logic [mesh_x*mesh_y-1:0]   ordy,
        output logic [mesh_x*mesh_y-1:0]   ovalid,
        output logic [noc_pkg::data_w-1:0] odata [mesh_x*mesh_y],
        output noc_pkg::coord_t            osrc_x [mesh_x*mesh_y],
        output noc_pkg::coord_t            osrc_y [mesh_x*mesh_y]
);
        import noc_pkg::*;

        localparam int num_nodes = mesh_x * mesh_y;

        // local links, node index n = y * mesh_x + x
        noc_link_if inj_l [num_nodes] ();
        noc_link_if ej_l [num_nodes] ();

        noc_inject #(
                .mesh_x (mesh_x),
                .mesh_y (mesh_y)
        ) u_inject (
                .clk, .rst_n,
                .ivalid, .idst_x, .idst_y, .idata, .ordy,
                .inj    (inj_l)
        );

        for (genvar gy = 0; gy < mesh_y; gy++) begin : g_y
                for (genvar gx = 0; gx < mesh_x; gx++) begin : g_x
                        localparam int n = gy * mesh_x + gx;

                        // router side of every port
                        noc_link_if in_l [num_ports] ();
                        noc_link_if out_l [num_ports] ();

                        noc_router #(
                                .my_x       (gx),
                                .my_y       (gy),
                                .mesh_x     (mesh_x),
                                .mesh_y     (mesh_y),
                                .fifo_depth (fifo_depth)
                        ) u_router (
                                .clk      (clk),
                                .rst_n    (rst_n),
                                .in_link  (in_l),
                                .out_link (out_l)
                        );

                        for (genvar d = 0; d < num_ports; d++) begin : g_port
                                // neighbour position and its facing port
                                localparam int nx = gx + ((d == port_east) ? 1 :
                                                          (d == port_west) ? -1 : 0);
                                localparam int ny = gy + ((d == port_south) ? 1 :
                                                          (d == port_north) ? -1 : 0);
                                localparam int od = (d + 2) % 4;

                                assign in_l[d].dir = port_e'(d);
                                assign out_l[d].dir = port_e'(d);

                                if (d == port_local) begin : g_local
                                        assign inj_l[n].dir = port_local;
                                        assign ej_l[n].dir = port_local;
                                        assign in_l[d].valid = inj_l[n].valid;
                                        assign in_l[d].flit = inj_l[n].flit;
                                        assign inj_l[n].rdy = in_l[d].rdy;
                                        assign ej_l[n].valid = out_l[d].valid;
                                        assign ej_l[n].flit = out_l[d].flit;
                                        assign out_l[d].rdy = ej_l[n].rdy;
                                end else if (nx >= 0 && nx < mesh_x &&
                                             ny >= 0 && ny < mesh_y) begin : g_link
                                        // each node drives its own inputs and output rdy
                                        assign in_l[d].valid = g_y[ny].g_x[nx].out_l[od].valid;
                                        assign in_l[d].flit = g_y[ny].g_x[nx].out_l[od].flit;
                                        assign out_l[d].rdy = g_y[ny].g_x[nx].in_l[od].rdy;
                                end else begin : g_edge
                                        // nothing enters from outside, anything leaving is sunk
                                        assign in_l[d].valid = 1'b0;
                                        assign in_l[d].flit = '0;
                                        assign out_l[d].rdy = 1'b1;
                                end
                        end
                end
        end

        noc_eject #(
                .mesh_x (mesh_x),
                .mesh_y (mesh_y)
        ) u_eject (
                .clk, .rst_n,
                .ej     (ej_l),
                .ovalid, .odata, .osrc_x, .osrc_y
        );

endmodule

// ==== tests/tb_noc.sv ====
/* noc mesh testbench
   directed flit traffic with a scoreboard, checks delivery, source stamp and order */
module tb_noc;
        import noc_pkg::*;

        localparam int num_nodes = mesh_x * mesh_y;
        localparam int cycle_limit = 20000;

        logic                 clk;
        logic                 rst_n;
        logic [num_nodes-1:0] ivalid;
        coord_t               idst_x [num_nodes];
        coord_t               idst_y [num_nodes];
        logic [data_w-1:0]    idata [num_nodes];
        logic [num_nodes-1:0] ordy;
        logic [num_nodes-1:0] ovalid;
        logic [data_w-1:0]    odata [num_nodes];
        coord_t               osrc_x [num_nodes];
        coord_t               osrc_y [num_nodes];

        // flits waiting for injection, and accepted flits not yet delivered
        flit_t traffic [$];
        flit_t exp_q [$];
        string test_name = "none";
        int    cyc = 0;
        int    last_arr_cyc = 0;
        int    last_inj_cyc = 0;

        noc_mesh #(
                .mesh_x     (mesh_x),
                .mesh_y     (mesh_y),
                .fifo_depth (2)
        ) dut0 (
                .clk, .rst_n,
                .ivalid, .idst_x, .idst_y, .idata, .ordy,
                .ovalid, .odata, .osrc_x, .osrc_y
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        task automatic stop_on_error();
                $display("SOME TESTS FAILED");
                $fatal(1);
        endtask

        // node n sits at x = n % mesh_x, y = n / mesh_x
        function automatic coord_t node_x(input int n);
                return coord_t'(n % mesh_x);
        endfunction

        function automatic coord_t node_y(input int n);
                return coord_t'(n / mesh_x);
        endfunction

        function automatic int src_node(input flit_t f);
                return int'(f.src_y) * mesh_x + int'(f.src_x);
        endfunction

        // 1 inject + 2 per router on the xy path + 1 eject
        function automatic int hop_latency(input int s, input int d);
                int dx;
                int dy;
                dx = (d % mesh_x) - (s % mesh_x);
                dy = (d / mesh_x) - (s / mesh_x);
                if (dx < 0)
                        dx = -dx;
                if (dy < 0)
                        dy = -dy;
                return 2 * (dx + dy + 1) + 2;
        endfunction

        // cycle count and run limit
        always @(posedge clk) begin
                cyc <= cyc + 1;
                if (cyc >= cycle_limit) begin
                        $display("timeout in %s, flits still in flight after %0d cycles",
                                test_name, cyc);
                        stop_on_error();
                end
        end

        // first outstanding flit for this node from this source, so order holds per pair
        task automatic check_arrival(input int n);
                int k;
                k = -1;
                for (int i = exp_q.size() - 1; i >= 0; i--) begin
                        if (exp_q[i].dst_x == node_x(n) && exp_q[i].dst_y == node_y(n) &&
                            exp_q[i].src_x == osrc_x[n] && exp_q[i].src_y == osrc_y[n])
                                k = i;
                end
                assert (k >= 0)
                else begin
                        $display("%s: node %0d got a flit from (%0d,%0d) never sent to it",
                                test_name, n, osrc_x[n], osrc_y[n]);
                        stop_on_error();
                end
                if (k >= 0) begin
                        assert (odata[n] == exp_q[k].data)
                        else begin
                                $display("error %s: node %0d from (%0d,%0d) expected %h actual %h",
                                        test_name, n, osrc_x[n], osrc_y[n],
                                        exp_q[k].data, odata[n]);
                                stop_on_error();
                        end
                        exp_q.delete(k);
                        last_arr_cyc = cyc;
                end
        endtask

        // monitor samples outputs at the edge
        always @(posedge clk) begin
                if (rst_n) begin
                        for (int n = 0; n < num_nodes; n++) begin
                                if (ovalid[n])
                                        check_arrival(n);
                        end
                end
        end

        task automatic queue_flit(input int s, input int d, input logic [data_w-1:0] data);
                flit_t f;
                f.dst_x = node_x(d);
                f.dst_y = node_y(d);
                f.src_x = node_x(s);
                f.src_y = node_y(s);
                f.data = data;
                traffic.push_back(f);
        endtask

        // each node offers its own flits in list order, a new one right after each accept
        task automatic drive_traffic();
                int                   cur [num_nodes];
                flit_t                held [num_nodes];
                logic [num_nodes-1:0] busy;
                int                   pending;
                pending = traffic.size();
                busy = '0;
                for (int n = 0; n < num_nodes; n++)
                        cur[n] = 0;
                do begin
                        for (int n = 0; n < num_nodes; n++) begin
                                // accepted on the edge just taken
                                if (busy[n] && ordy[n]) begin
                                        exp_q.push_back(held[n]);
                                        last_inj_cyc = cyc;
                                        busy[n] = 1'b0;
                                end
                                if (!busy[n]) begin
                                        while (cur[n] < traffic.size() &&
                                               src_node(traffic[cur[n]]) != n)
                                                cur[n]++;
                                        if (cur[n] < traffic.size()) begin
                                                held[n] = traffic[cur[n]];
                                                cur[n]++;
                                                pending--;
                                                busy[n] = 1'b1;
                                                ivalid[n] <= 1'b1;
                                                idst_x[n] <= held[n].dst_x;
                                                idst_y[n] <= held[n].dst_y;
                                                idata[n] <= held[n].data;
                                        end else begin
                                                ivalid[n] <= 1'b0;
                                        end
                                end
                        end
                        @(posedge clk);
                end while (pending > 0 || busy != '0);
                traffic.delete();
        endtask

        // inject the list and wait for the scoreboard to empty
        task automatic run_traffic();
                drive_traffic();
                while (exp_q.size() != 0)
                        @(posedge clk);
                // room for a stray duplicate to show up
                repeat (20) @(posedge clk);
        endtask

        // uncontended delivery must meet the xy path latency
        task automatic check_latency(input int s, input int d);
                int lat;
                lat = last_arr_cyc - last_inj_cyc;
                assert (lat <= hop_latency(s, d))
                else begin
                        $display("error %s: latency %0d to %0d expected %0d actual %0d",
                                test_name, s, d, hop_latency(s, d), lat);
                        stop_on_error();
                end
        endtask

        task automatic test_reset();
                test_name = "reset";
                repeat (4) begin
                        @(posedge clk);
                        assert (ovalid == '0)
                        else begin
                                $display("error %s: ovalid expected %h actual %h",
                                        test_name, {num_nodes{1'b0}}, ovalid);
                                stop_on_error();
                        end
                        assert (ordy == '1)
                        else begin
                                $display("error %s: ordy expected %h actual %h",
                                        test_name, {num_nodes{1'b1}}, ordy);
                                stop_on_error();
                        end
                end
        endtask

        task automatic test_single_pairs();
                test_name = "single_pairs";
                for (int s = 0; s < num_nodes; s++) begin
                        for (int d = 0; d < num_nodes; d++) begin
                                queue_flit(s, d, {8'h51, 8'(s), 8'(d), 8'($urandom)});
                                run_traffic();
                                check_latency(s, d);
                        end
                end
        endtask

        task automatic test_self();
                test_name = "self";
                for (int n = 0; n < num_nodes; n++)
                        queue_flit(n, n, {8'h5e, 8'(n), 16'($urandom)});
                run_traffic();
        endtask

        // every node sends four numbered flits to the centre
        task automatic test_hotspot();
                int centre;
                test_name = "hotspot";
                centre = (mesh_y / 2) * mesh_x + mesh_x / 2;
                for (int k = 0; k < 4; k++) begin
                        for (int s = 0; s < num_nodes; s++)
                                queue_flit(s, centre, {8'h40, 8'(s), 8'(k), 8'($urandom)});
                end
                run_traffic();
        endtask

        task automatic test_random();
                int s;
                int d;
                test_name = "random";
                for (int i = 0; i < 300; i++) begin
                        s = $urandom_range(num_nodes - 1);
                        d = $urandom_range(num_nodes - 1);
                        queue_flit(s, d, $urandom);
                end
                run_traffic();
        endtask

        initial begin
                void'($urandom(32'hcaed));
                rst_n = 1'b0;
                ivalid = '0;
                for (int n = 0; n < num_nodes; n++) begin
                        idst_x[n] = '0;
                        idst_y[n] = '0;
                        idata[n] = '0;
                end
                repeat (10) @(posedge clk);
                rst_n <= 1'b1;
                test_reset();
                test_single_pairs();
                test_self();
                test_hotspot();
                test_random();
                $display("ALL TESTS PASSED");
                $finish;
        end

endmodule

// ==== tb.f ====
source/noc_pkg.sv
source/noc_link_if.sv
source/noc_input_fifo.sv
source/noc_output_arbiter.sv
source/noc_router.sv
source/noc_inject.sv
source/noc_eject.sv
source/noc_mesh.sv
tests/tb_noc.sv

// ==== Bender.yml ====
package:
  name: noc_mesh

sources:
  - source/noc_pkg.sv
  - source/noc_link_if.sv
  - source/noc_input_fifo.sv
  - source/noc_output_arbiter.sv
  - source/noc_router.sv
  - source/noc_inject.sv
  - source/noc_eject.sv
  - source/noc_mesh.sv
  - target: test
    files:
      - tests/tb_noc.sv
